// ==== source/cpu_pkg.sv ====
// Shared types of the reduced 8080 core
// Data, address and register index types
// Control state and ALU operation enums, flag bit positions
`default_nettype none

package cpu_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [2:0] reg_idx_t; // 8080 numbering, 6 (M) never used

	// Order follows opcode bits 5:3
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBB,
		ALU_ANA,
		ALU_XRA,
		ALU_ORA,
		ALU_CMP
	} alu_op_t;

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		IMM,        // Immediate byte of MVI and ALU immediate
		ALU_EXEC,
		JMP_LO,
		JMP_HI,
		LXI_LO,
		LXI_HI,
		DIR_LO,     // Address bytes of LDA / STA
		DIR_HI,
		DIR_ACCESS,
		HALT
	} cpu_state_t;

	localparam int FLAG_S = 7;
	localparam int FLAG_Z = 6;
	localparam int FLAG_P = 2;
	localparam int FLAG_C = 0;

endpackage

`default_nettype wire

// ==== source/bus_if.sv ====
// Memory access request between core and bus port
`timescale 1ns/10ps
`default_nettype none

interface bus_if;
	import cpu_pkg::*;

	logic read;
	logic write;
	addr_t addr;
	byte_t wdata;
	byte_t rdata;  // Valid with done on a read
	logic done;    // One-cycle pulse at end of access

	modport core (
		output read, write, addr, wdata,
		input rdata, done
	);

	modport port (
		input read, write, addr, wdata,
		output rdata, done
	);

endinterface

`default_nettype wire

// ==== source/bus_port.sv ====
// Pin-side bus engine
// Acknowledge synchronizer, four-edge req/ack handshake
// Address low / address high / data transfer sequence
`timescale 1ns/10ps
`default_nettype none

module bus_port #(
	parameter int SYNC_STAGES = 2
) (
	input logic clk,
	input logic rst_n,
	bus_if.port bus,
	input logic ack,
	output logic req,
	output cpu_pkg::byte_t bus_out,
	output logic bus_oe,
	input cpu_pkg::byte_t bus_in
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {PH_IDLE, PH_ADDR_LO, PH_ADDR_HI, PH_DATA} phase_t;

	phase_t phase, phase_nxt;
	logic [SYNC_STAGES-1:0] ack_sync;
	logic ack_s;
	logic armed;       // ack seen low since last transfer
	logic xfer_valid;
	logic xfer_ready;
	logic drive;
	byte_t rdata_q;

	assign ack_s = ack_sync[SYNC_STAGES-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_sync <= '0;
			armed <= 1'b0;
			req <= 1'b0;
			xfer_ready <= 1'b0;
			phase <= PH_IDLE;
		end else begin
			ack_sync <= (ack_sync << 1) | SYNC_STAGES'(ack);
			phase <= phase_nxt;
			xfer_ready <= 1'b0;
			if (!armed) begin
				if (!ack_s)
					armed <= 1'b1;
			end else begin
				if (xfer_valid && !ack_s)
					req <= 1'b1;
				if (ack_s && req) begin // Transfer complete
					xfer_ready <= 1'b1;
					req <= 1'b0;
					armed <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (phase == PH_DATA && ack_s && req)
			rdata_q <= bus_in;
	end

	always_comb begin
		phase_nxt = phase;
		xfer_valid = 1'b1;
		drive = 1'b1;
		bus_out = bus.wdata;
		bus.done = 1'b0;
		case (phase)
			PH_IDLE: begin
				xfer_valid = 1'b0;
				drive = 1'b0;
				if (bus.read || bus.write)
					phase_nxt = PH_ADDR_LO;
			end
			PH_ADDR_LO: begin
				bus_out = bus.addr[7:0];
				if (xfer_ready)
					phase_nxt = PH_ADDR_HI;
			end
			PH_ADDR_HI: begin
				bus_out = bus.addr[15:8];
				if (xfer_ready)
					phase_nxt = PH_DATA;
			end
			PH_DATA: begin
				drive = bus.write; // Pins released for a read
				if (xfer_ready) begin
					bus.done = 1'b1;
					phase_nxt = PH_IDLE;
				end
			end
			default: phase_nxt = PH_IDLE;
		endcase
	end

	assign bus_oe = req && drive;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/cpu_regfile.sv ====
// Register file B C D E H L A and flags register
// One write port, one indexed read port plus the accumulator
`timescale 1ns/10ps
`default_nettype none

module cpu_regfile (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input cpu_pkg::reg_idx_t wr_idx,
	input cpu_pkg::byte_t wr_data,
	input cpu_pkg::reg_idx_t rd_idx,
	output cpu_pkg::byte_t rd_data,
	output cpu_pkg::byte_t acc,
	input logic flags_en,
	input cpu_pkg::byte_t flags_in,
	output cpu_pkg::byte_t flags
);
	import cpu_pkg::*;

	localparam byte_t FLAG_MASK =
		byte_t'((1 << FLAG_S) | (1 << FLAG_Z) | (1 << FLAG_P) | (1 << FLAG_C));

	byte_t reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a;
	byte_t flags_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a} <= '0;
			flags_q <= '0;
		end else begin
			if (wr_en) begin
				case (wr_idx)
					3'd0: reg_b <= wr_data;
					3'd1: reg_c <= wr_data;
					3'd2: reg_d <= wr_data;
					3'd3: reg_e <= wr_data;
					3'd4: reg_h <= wr_data;
					3'd5: reg_l <= wr_data;
					3'd7: reg_a <= wr_data;
					default: ;
				endcase
			end
			if (flags_en)
				flags_q <= flags_in & FLAG_MASK;
		end
	end

	always_comb begin
		case (rd_idx)
			3'd0: rd_data = reg_b;
			3'd1: rd_data = reg_c;
			3'd2: rd_data = reg_d;
			3'd3: rd_data = reg_e;
			3'd4: rd_data = reg_h;
			3'd5: rd_data = reg_l;
			3'd7: rd_data = reg_a;
			default: rd_data = '0;
		endcase
	end

	assign acc = reg_a;
	assign flags = flags_q | 8'h02; // Bit 1 always set on the 8080

endmodule

`default_nettype wire

// ==== source/cpu_alu.sv ====
// Accumulator ALU
// Add / subtract with carry or borrow, AND, XOR, OR, compare
// Sign, zero, parity and carry results
`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
	input cpu_pkg::alu_op_t op,
	input cpu_pkg::byte_t acc,
	input cpu_pkg::byte_t operand,
	input logic carry_in,
	output cpu_pkg::byte_t result,
	output cpu_pkg::byte_t flags_out
);
	import cpu_pkg::*;

	logic [8:0] sum;
	logic cy_in;
	logic carry;

	always_comb begin
		cy_in = carry_in && (op == ALU_ADC || op == ALU_SBB);
		sum = '0;
		result = '0;
		carry = 1'b0;
		case (op)
			ALU_ADD, ALU_ADC: begin
				sum = {1'b0, acc} + {1'b0, operand} + 9'(cy_in);
				result = sum[7:0];
				carry = sum[8];
			end
			ALU_SUB, ALU_SBB, ALU_CMP: begin
				sum = {1'b0, acc} - {1'b0, operand} - 9'(cy_in);
				result = sum[7:0];
				carry = sum[8]; // Borrow
			end
			ALU_ANA: result = acc & operand;
			ALU_XRA: result = acc ^ operand;
			ALU_ORA: result = acc | operand;
			default: result = acc;
		endcase
	end

	always_comb begin
		flags_out = '0;
		flags_out[FLAG_S] = result[7];
		flags_out[FLAG_Z] = result == 8'h00;
		flags_out[FLAG_P] = ~^result; // Even parity
		flags_out[FLAG_C] = carry;
	end

endmodule

`default_nettype wire

// ==== source/cpu_control.sv ====
// Instruction sequencer of the reduced 8080
// Decode, PC, IR, immediate latch and direct-address latch
// Register file write steering and bus requests
`timescale 1ns/10ps
`default_nettype none

module cpu_control (
	input logic clk,
	input logic rst_n,
	bus_if.core bus,
	output logic mem_read,
	output logic mem_write,
	output logic halted,
	output logic wr_en,
	output cpu_pkg::reg_idx_t wr_idx,
	output cpu_pkg::byte_t wr_data,
	output cpu_pkg::reg_idx_t rd_idx,
	input cpu_pkg::byte_t rd_data,
	input cpu_pkg::byte_t acc,
	output logic flags_en,
	output cpu_pkg::byte_t flags_in,
	input cpu_pkg::byte_t flags,
	output cpu_pkg::alu_op_t alu_op,
	output cpu_pkg::byte_t alu_operand,
	input cpu_pkg::byte_t alu_result,
	input cpu_pkg::byte_t alu_flags
);
	import cpu_pkg::*;

	cpu_state_t state, decode_nxt;
	addr_t pc;
	addr_t addr_lat;
	byte_t ir;
	byte_t imm;
	logic is_mov, is_hlt, is_mvi, is_alu, is_alui;
	logic is_jmp, is_jcc, is_lxi, is_lda, is_sta;
	logic cond;

	assign is_hlt = ir == 8'h76;
	assign is_mov = ir[7:6] == 2'b01 && ir[5:3] != 3'd6 && ir[2:0] != 3'd6;
	assign is_mvi = ir[7:6] == 2'b00 && ir[2:0] == 3'b110 && ir[5:3] != 3'd6;
	assign is_alu = ir[7:6] == 2'b10 && ir[2:0] != 3'd6;
	assign is_alui = ir[7:6] == 2'b11 && ir[2:0] == 3'b110;
	assign is_jmp = ir == 8'hC3;
	assign is_jcc = ir[7:6] == 2'b11 && ir[2:0] == 3'b010;
	assign is_lxi = ir[7:6] == 2'b00 && ir[3:0] == 4'b0001 && ir[5:4] != 2'b11;
	assign is_lda = ir == 8'h3A;
	assign is_sta = ir == 8'h32;

	always_comb begin
		case (ir[5:3])
			3'd0: cond = !flags[FLAG_Z];
			3'd1: cond = flags[FLAG_Z];
			3'd2: cond = !flags[FLAG_C];
			3'd3: cond = flags[FLAG_C];
			3'd4: cond = !flags[FLAG_P]; // Parity odd
			3'd5: cond = flags[FLAG_P];
			3'd6: cond = !flags[FLAG_S]; // Plus
			default: cond = flags[FLAG_S];
		endcase
	end

	always_comb begin
		if (is_hlt)
			decode_nxt = HALT;
		else if (is_mvi || is_alui)
			decode_nxt = IMM;
		else if (is_alu)
			decode_nxt = ALU_EXEC;
		else if (is_jmp || is_jcc)
			decode_nxt = JMP_LO;
		else if (is_lxi)
			decode_nxt = LXI_LO;
		else if (is_lda || is_sta)
			decode_nxt = DIR_LO;
		else
			decode_nxt = FETCH; // MOV completes in DECODE, others are NOPs
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FETCH;
			pc <= '0;
			ir <= '0;
		end else begin
			case (state)
				FETCH: if (bus.done) begin
					ir <= bus.rdata;
					pc <= pc + 16'd1;
					state <= DECODE;
				end
				DECODE: state <= decode_nxt;
				IMM: if (bus.done) begin
					pc <= pc + 16'd1;
					state <= is_alui ? ALU_EXEC : FETCH;
				end
				ALU_EXEC: state <= FETCH;
				JMP_LO, LXI_LO, DIR_LO, DIR_HI: if (bus.done) begin
					pc <= pc + 16'd1;
					state <= cpu_state_t'(state + 4'd1); // Next byte of same instruction
				end
				JMP_HI: if (bus.done) begin
					pc <= (is_jmp || cond) ? {bus.rdata, addr_lat[7:0]} : pc + 16'd1;
					state <= FETCH;
				end
				LXI_HI: if (bus.done) begin
					pc <= pc + 16'd1;
					state <= FETCH;
				end
				DIR_ACCESS: if (bus.done)
					state <= FETCH;
				HALT: state <= HALT;
				default: state <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bus.done) begin
			if (state == IMM)
				imm <= bus.rdata;
			if (state == JMP_LO || state == DIR_LO)
				addr_lat[7:0] <= bus.rdata;
			if (state == DIR_HI)
				addr_lat[15:8] <= bus.rdata;
		end
	end

	always_comb begin
		wr_en = 1'b0;
		wr_idx = ir[5:3];
		wr_data = bus.rdata;
		case (state)
			DECODE: begin
				wr_en = is_mov;
				wr_data = rd_data;
			end
			IMM: wr_en = bus.done && is_mvi;
			ALU_EXEC: begin
				wr_en = alu_op != ALU_CMP;
				wr_idx = reg_idx_t'(7); // A
				wr_data = alu_result;
			end
			LXI_LO: begin
				wr_en = bus.done;
				wr_idx = {ir[5:4], 1'b1}; // Low register C, E or L
			end
			LXI_HI: begin
				wr_en = bus.done;
				wr_idx = {ir[5:4], 1'b0};
			end
			DIR_ACCESS: begin
				wr_en = bus.done && is_lda;
				wr_idx = reg_idx_t'(7);
			end
			default: ;
		endcase
	end

	assign rd_idx = ir[2:0];
	assign alu_op = alu_op_t'(ir[5:3]);
	assign alu_operand = is_alui ? imm : rd_data;
	assign flags_en = state == ALU_EXEC;
	assign flags_in = alu_flags;

	assign bus.read = state == FETCH || state == IMM || state == JMP_LO || state == JMP_HI
		|| state == LXI_LO || state == LXI_HI || state == DIR_LO || state == DIR_HI
		|| (state == DIR_ACCESS && is_lda);
	assign bus.write = state == DIR_ACCESS && is_sta;
	assign bus.addr = (state == DIR_ACCESS) ? addr_lat : pc;
	assign bus.wdata = acc; // Only STA writes

	assign mem_read = bus.read;
	assign mem_write = bus.write;
	assign halted = state == HALT;

endmodule

`default_nettype wire

// ==== source/i8080_lite_top.sv ====
// Top level of the reduced 8080
// Control, register file, ALU and bus port on plain pins
`timescale 1ns/10ps
`default_nettype none

module i8080_lite_top #(
	parameter int SYNC_STAGES = 2
) (
	input logic clk,
	input logic rst_n,
	input logic ack,
	output logic req,
	output cpu_pkg::byte_t bus_out,
	output logic bus_oe,
	input cpu_pkg::byte_t bus_in,
	output logic mem_read,
	output logic mem_write,
	output logic halted
);
	import cpu_pkg::*;

	logic wr_en, flags_en;
	reg_idx_t wr_idx, rd_idx;
	byte_t wr_data, rd_data, acc, flags_in, flags;
	alu_op_t alu_op;
	byte_t alu_operand, alu_result, alu_flags;

	bus_if u_bus ();

	cpu_control u_cpu_control (
		.clk, .rst_n, .bus(u_bus.core), .mem_read, .mem_write, .halted,
		.wr_en, .wr_idx, .wr_data, .rd_idx, .rd_data, .acc,
		.flags_en, .flags_in, .flags,
		.alu_op, .alu_operand, .alu_result, .alu_flags
	);

	cpu_regfile u_cpu_regfile (
		.clk, .rst_n, .wr_en, .wr_idx, .wr_data, .rd_idx, .rd_data, .acc,
		.flags_en, .flags_in, .flags
	);

	cpu_alu u_cpu_alu (
		.op(alu_op), .acc, .operand(alu_operand), .carry_in(flags[FLAG_C]),
		.result(alu_result), .flags_out(alu_flags)
	);

	bus_port #(.SYNC_STAGES(SYNC_STAGES)) u_bus_port (
		.clk, .rst_n, .bus(u_bus.port), .ack, .req, .bus_out, .bus_oe, .bus_in
	);

endmodule

`default_nettype wire

// ==== tb/i8080_lite_asserts.sv ====
// Bus protocol assertions, bound into the bus port
`timescale 1ns/10ps
`default_nettype none

module i8080_lite_asserts (
	input logic clk,
	input logic rst_n,
	input logic read,
	input logic write,
	input logic req,
	input logic ack_s,
	input logic bus_oe
);
	int unsigned fail_count = 0; // Read by the testbench

	a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write)) else begin
		$error("read and write requested together");
		fail_count++;
	end

	a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(req) |-> !$past(ack_s)) else begin
		$error("req raised while synchronized ack was high");
		fail_count++;
	end

	a_oe_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!req |-> !bus_oe) else begin
		$error("bus_oe high without req");
		fail_count++;
	end

endmodule

bind bus_port i8080_lite_asserts u_bus_asserts (
	.clk(clk), .rst_n(rst_n), .read(bus.read), .write(bus.write),
	.req(req), .ack_s(ack_s), .bus_oe(bus_oe)
);

`default_nettype wire

// ==== tb/i8080_lite_tb.sv ====
// Testbench of the reduced 8080
// Clock, reset, handshaking 64 KiB memory model
// Program images and expected writes from the vectors file
`timescale 1ns/10ps
`default_nettype none

module i8080_lite_tb;
	import cpu_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int QUIET_CYCLES = 50;
	localparam int BASE_LIMIT = 2000;
	localparam int CYCLES_PER_ACCESS = 40; // Three transfers of up to about 11 cycles
	localparam int PH_ADDR_LO = 0;
	localparam int PH_ADDR_HI = 1;
	localparam int PH_DATA = 2;

	logic clk;
	logic rst_n;
	logic ack;
	logic req;
	byte_t bus_out;
	logic bus_oe;
	byte_t bus_in;
	logic mem_read;
	logic mem_write;
	logic halted;

	byte_t mem [0:65535];
	logic [23:0] vec [0:1023];
	logic [23:0] writes_seen [$];
	logic [23:0] writes_exp [$];
	addr_t addr_q;
	int phase;
	int delay;
	integer seed;
	int errors;
	int passed;
	int failed;
	int pin_errors;
	string cur_test;
	logic timed_out;
	string test_names [6] = '{"mov_sta", "alu_ops", "cond_jumps", "lxi_lda_sta",
		"halt", "unsupported"};

	i8080_lite_top #(.SYNC_STAGES(2)) u_i8080_lite_top (
		.clk, .rst_n, .ack, .req, .bus_out, .bus_oe, .bus_in,
		.mem_read, .mem_write, .halted
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Memory side of the four-edge req/ack handshake
	always @(negedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
			phase <= PH_ADDR_LO;
			delay <= $unsigned($random(seed)) % 4;
		end else if (!ack) begin
			if (req && delay > 0) begin
				delay <= delay - 1;
			end else if (req) begin
				ack <= 1'b1;
				if (bus_oe !== (phase != PH_DATA || mem_write)) begin
					$display("Fail %s: bus_oe in transfer %0d expected %b actual %b",
						cur_test, phase, (phase != PH_DATA || mem_write), bus_oe);
					pin_errors++;
				end
				case (phase)
					PH_ADDR_LO: addr_q[7:0] <= bus_out;
					PH_ADDR_HI: addr_q[15:8] <= bus_out;
					default: begin
						if (mem_read === mem_write) begin
							$display("Fail %s: mem_read in data transfer expected %b actual %b",
								cur_test, !mem_write, mem_read);
							pin_errors++;
						end
						if (mem_write) begin
							mem[addr_q] <= bus_out;
							writes_seen.push_back({addr_q, bus_out});
						end else begin
							bus_in <= mem[addr_q];
						end
					end
				endcase
			end
		end else if (!req) begin
			ack <= 1'b0;
			phase <= (phase == PH_DATA) ? PH_ADDR_LO : phase + 1;
			delay <= $unsigned($random(seed)) % 4;
		end
	end

	task automatic load_program(input int first, input int n);
		for (int a = 0; a < 65536; a++)
			mem[a] = byte_t'(a[15:8] ^ a[7:0] ^ 8'hA5);
		for (int i = 0; i < n; i++)
			mem[i] = vec[first + i][7:0];
	endtask

	task automatic run_test(input int t, input int limit);
		int cycles;
		int quiet_bad;
		int errs;
		string name;
		logic [23:0] e;
		logic [23:0] s;
		name = (t < 6) ? test_names[t] : "extra";
		cur_test = name;
		pin_errors = 0;
		cycles = 0;
		quiet_bad = 0;
		errs = 0;
		writes_seen.delete();
		@(negedge clk);
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n <= 1'b1;
		while (!halted && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("Timeout: %s did not reach HLT within %0d cycles", name, limit);
			errs++;
			timed_out = 1'b1;
		end else begin
			repeat (QUIET_CYCLES) begin
				@(negedge clk);
				if (mem_read || mem_write || req || !halted)
					quiet_bad++;
			end
			if (quiet_bad != 0) begin
				$display("%s: bus activity or halt lost after HLT", name);
				errs++;
			end
			for (int i = 0; i < writes_exp.size(); i++) begin
				e = writes_exp[i];
				if (i >= writes_seen.size()) begin
					$display("%s: expected write %h/%h never happened", name, e[23:8], e[7:0]);
					errs++;
				end else if (writes_seen[i] != e) begin
					s = writes_seen[i];
					$display("Fail %s: write %0d expected %h/%h actual %h/%h", name, i,
						e[23:8], e[7:0], s[23:8], s[7:0]);
					errs++;
				end
			end
			if (writes_seen.size() > writes_exp.size()) begin
				$display("%s: %0d more writes than expected", name,
					writes_seen.size() - writes_exp.size());
				errs++;
			end
		end
		errs += pin_errors;
		if (errs == 0) begin
			passed++;
			$display("%s: passed", name);
		end else begin
			failed++;
			$display("%s: failed with %0d errors", name, errs);
		end
		errors += errs;
	endtask

	initial begin
		int p;
		int n;
		int w;
		int t;
		seed = 40;
		rst_n = 1'b0;
		ack = 1'b0;
		bus_in = '0;
		errors = 0;
		passed = 0;
		failed = 0;
		pin_errors = 0;
		cur_test = "";
		timed_out = 1'b0;
		for (int i = 0; i < 1024; i++)
			vec[i] = '0;
		$readmemh("tb/i8080_lite_vectors.txt", vec);
		p = 0;
		t = 0;
		while (vec[p] != 0 && !timed_out) begin // Zero length ends the list
			n = vec[p];
			w = vec[p + n + 1];
			load_program(p + 1, n);
			writes_exp.delete();
			for (int i = 0; i < w; i++)
				writes_exp.push_back(vec[p + n + 2 + i]);
			p = p + n + w + 2;
			run_test(t, BASE_LIMIT + CYCLES_PER_ACCESS * (n + w));
			t++;
		end
		if (t == 0) begin
			$display("No test vectors were loaded");
			errors++;
		end
		if (u_i8080_lite_top.u_bus_port.u_bus_asserts.fail_count != 0) begin
			$display("Bus protocol assertions failed %0d times",
				u_i8080_lite_top.u_bus_port.u_bus_asserts.fail_count);
			errors++;
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
			t, passed, failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== i8080_lite.f ====
source/cpu_pkg.sv
source/bus_if.sv
source/bus_port.sv
source/cpu_regfile.sv
source/cpu_alu.sv
source/cpu_control.sv
source/i8080_lite_top.sv
tb/i8080_lite_asserts.sv
tb/i8080_lite_tb.sv

// ==== Bender.yml ====
package:
  name: i8080_lite

sources:
  - source/cpu_pkg.sv
  - source/bus_if.sv
  - source/bus_port.sv
  - source/cpu_regfile.sv
  - source/cpu_alu.sv
  - source/cpu_control.sv
  - source/i8080_lite_top.sv
  - target: test
    files:
      - tb/i8080_lite_asserts.sv
      - tb/i8080_lite_tb.sv

// ==== tb/i8080_lite_vectors.txt ====
// Per test: program length N, then N bytes loaded from address 0,
// then write count W and W expected writes as aaaadd (address, data); 00 ends the list
// mov_sta
15 06 12 48 51 5A 63 6C 7D 32 00 80 3E 34 47 3E 00 78 32 01 80 76
02 800012 800134
// alu_ops
3F 3E 3C 06 0F 80 32 10 80 3E F0 C6 20 CE 05 32 11 80
3E 10 D6 20 DE 01 32 12 80 0E 0F A1 F6 50 EE FF 32 13 80
16 A1 BA 32 14 80 1E 01 3E 00 93 9B 32 15 80
3E FF 83 88 32 16 80 AF 32 17 80 76
08 80104B 801116 8012EE 8013A1 8014A1 8015FD 801610 801700
// cond_jumps
51 3E 01 D6 01 CA 0C 00 3E EE 32 20 80 3E 11 32 21 80
C2 19 00 3E 22 32 22 80 3E 80 C6 90 DA 23 00 32 23 80
E2 29 00 32 24 80 3E 33 32 25 80 3E 7F C6 01 F2 38 00 32 26 80
FA 3E 00 32 27 80 D2 44 00 32 28 80 EA 4A 00 32 29 80
C3 50 00 32 2A 80 76
05 802111 802222 802533 802680 802980
// lxi_lda_sta
34 01 34 12 11 78 56 21 BC 9A 78 32 30 80 79 32 31 80
7A 32 32 80 7B 32 33 80 7C 32 34 80 7D 32 35 80
3E 00 3A 32 80 32 40 80 3A 35 80 47 3E 00 78 32 41 80 76
08 803012 803134 803256 803378 80349A 8035BC 804056 8041BC
// halt
0A 3E 5A 32 50 80 76 32 51 80 76
01 80505A
// unsupported
17 3E 21 7E 77 86 04 3C 07 2F 37 C5 C9 E9 00 32 60 80 CE 00 32 61 80 76
02 806021 806121
00
